// ==== verilog.f ====
hw/femtoPkg.sv
hw/memBus.sv
hw/femtoCore.sv
hw/busSplit.sv
hw/progRam.sv
hw/consoleOut.sv
hw/femtoSoc.sv
tb/clockGen.sv
tb/consoleMonitor.sv
tb/femtoSocTb.sv

// ==== Bender.yml ====
package:
  name: femto_soc

sources:
  - files:
      - hw/femtoPkg.sv
      - hw/memBus.sv
      - hw/femtoCore.sv
      - hw/busSplit.sv
      - hw/progRam.sv
      - hw/consoleOut.sv
      - hw/femtoSoc.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/consoleMonitor.sv
      - tb/femtoSocTb.sv

// ==== tb/prog.hex ====
// One RV32I instruction word per line, from address 0, comment gives the assembly
// x10 holds the console base 0x0040_0000, x3 carries each result
00400537 // lui x10,0x400
00052283 // lw x5,0(x10) credits
00552023 // sw x5,0(x10)
06400093 // addi x1,x0,100
FF900113 // addi x2,x0,-7
002081B3 // add x3,x1,x2
00352023 // sw x3,0(x10)
402081B3 // sub
00352023
0020C1B3 // xor
00352023
0020E1B3 // or
00352023
0020F1B3 // and
00352023
001121B3 // slt x3,x2,x1
00352023
001131B3 // sltu x3,x2,x1
00352023
123451B7 // lui x3,0x12345
00352023
00001197 // auipc x3,1 at 0x54
00352023
00111193 // slli x3,x2,1
00352023
01F15193 // srli x3,x2,31
00352023
41F15193 // srai x3,x2,31
00352023
400151B3 // sra x3,x2,x0
00352023
00115193 // srli x3,x2,1
00352023
40115193 // srai x3,x2,1
00352023
40000213 // addi x4,x0,0x400
00222023 // sw x2,0(x4)
08500313 // addi x6,x0,0x85
006200A3 // sb x6,1(x4)
00121123 // sh x1,2(x4)
00022183 // lw x3,0(x4)
00352023
00120183 // lb x3,1(x4)
00352023
00124183 // lbu x3,1(x4)
00352023
00021183 // lh x3,0(x4)
00352023
00225183 // lhu x3,2(x4)
00352023
006201A3 // sb x6,3(x4)
00022183 // lw x3,0(x4)
00352023
11100193 // beq block at 0xd4
00208463
22100193
00352023
11200193 // bne block
00209463
22200193
00352023
11300193 // blt block
00114463
22300193
00352023
11400193 // bge block
00115463
22400193
00352023
11500193 // bltu block
00116463
22500193
00352023
11600193 // bgeu block
00117463
22600193
00352023
008001EF // jal x3,+8 at 0x134
33300193 // skipped
00352023
00000417 // auipc x8,0 at 0x140
00C401E7 // jalr x3,12(x8)
44400193 // skipped
00352023
0000006F // jal x0,0 park

// ==== tb/femtoSocTb.sv ====
//******************************
// femtoSocTb
// Runs the test program, returns credits, reports the result
//******************************

module femtoSocTb;
   import femtoPkg::*;

   localparam int         maxRows    = 32;
   localparam int         progInstrs = 85;  // Words in prog.hex
   localparam logic [3:0] credits    = 4'd4;

   logic  clk;
   logic  reset;
   logic  creditReturn;
   logic  txValid;
   word_t txData;

   word_t expTable  [maxRows];   // Expected console words, program order
   int    groupTable[maxRows];   // Behavior tag per row
   int    waitTable [maxRows];   // Cycles before the credit goes back
   int    rows;
   int    received;
   int    passCount;
   int    failCount;
   int    cycles;
   int    cycleLimit;
   int    seed;
   word_t expWord;
   int    expGroup;

   clockGen #(.period(100), .resetCycles(2)) clocks (.clk(clk), .reset(reset));

   femtoSoc #(.consoleCredits(credits)) UUT (
      .clk          (clk),
      .reset        (reset),
      .txValid      (txValid),
      .txData       (txData),
      .creditReturn (creditReturn)
   );

   consoleMonitor #(.credits(credits)) monitor (
      .clk          (clk),
      .reset        (reset),
      .txValid      (txValid),
      .txData       (txData),
      .creditReturn (creditReturn),
      .expWord      (expWord),
      .expGroup     (expGroup),
      .rows         (rows),
      .received     (received),
      .passCount    (passCount),
      .failCount    (failCount)
   );

   assign expWord  = (received < rows) ? expTable[received] : '0;
   assign expGroup = (received < rows) ? groupTable[received] : 0;

   task automatic addRow(input word_t value, input int group, input int waitCycles);
      expTable[rows]   = value;
      groupTable[rows] = group;
      waitTable[rows]  = waitCycles;
      rows             = rows + 1;
   endtask

   // One credit pulse, one cycle wide
   task automatic returnCredit(input int waitCycles);
      repeat (waitCycles) @(posedge clk);
      @(posedge clk);
      #10 creditReturn = 1'b1;
      @(posedge clk);
      #10 creditReturn = 1'b0;
   endtask

   //******************************
   // Expected table
   //******************************
   task automatic buildTable;
      word_t a;
      word_t b;
      word_t mem;     // Data word at 0x400
      int    w;
      a = 32'd100;
      b = -32'sd7;
      // Console base 0x0040_0000, first read gives the full grant
      addRow(32'(credits), 5, 0);
      addRow(a + b, 1, 2);
      addRow(a - b, 1, 2);
      addRow(a ^ b, 1, 2);
      addRow(a | b, 1, 2);
      addRow(a & b, 1, 2);
      addRow(($signed(b) < $signed(a)) ? 32'd1 : 32'd0, 1, 2);  // SLT
      addRow((b < a) ? 32'd1 : 32'd0, 1, 2);                    // SLTU
      addRow(32'h12345 << 12, 1, 2);
      addRow(32'h54 + (32'h1 << 12), 1, 2);  // AUIPC at 0x54
      // Withheld credits, output must stall and keep order
      for (int i = 0; i < 6; i++) begin
         w = 20 + ($random(seed) & 15);
         case (i)
            0: addRow(b << 1, 2, w);
            1: addRow(b >> 31, 2, w);
            2: addRow($signed(b) >>> 31, 2, w);
            3: addRow(b, 2, w);                  // Shift by zero
            4: addRow(b >> 1, 2, w);
            default: addRow($signed(b) >>> 1, 2, w);
         endcase
      end
      mem          = b;
      mem[15:8]    = 8'h85;
      mem[31:16]   = a[15:0];
      addRow(mem, 3, 1);
      addRow({{24{mem[15]}}, mem[15:8]}, 3, 1);   // LB lane 1
      addRow({24'b0, mem[15:8]}, 3, 1);           // LBU
      addRow({{16{mem[15]}}, mem[15:0]}, 3, 1);   // LH
      addRow({16'b0, mem[31:16]}, 3, 1);          // LHU
      mem[31:24]   = 8'h85;
      addRow(mem, 3, 1);
      // Taken marker 0x11k, untaken 0x22k
      addRow((a == b) ? 32'h111 : 32'h221, 4, 3);
      addRow((a != b) ? 32'h112 : 32'h222, 4, 3);
      addRow(($signed(b) < $signed(a)) ? 32'h113 : 32'h223, 4, 3);
      addRow(($signed(b) >= $signed(a)) ? 32'h114 : 32'h224, 4, 3);
      addRow((b < a) ? 32'h115 : 32'h225, 4, 3);
      addRow((b >= a) ? 32'h116 : 32'h226, 4, 3);
      addRow(32'h134 + 32'd4, 4, 0);  // JAL link
      addRow(32'h144 + 32'd4, 4, 0);  // JALR link
   endtask

   //******************************
   // Run
   //******************************
   initial begin
      creditReturn = 1'b0;
      seed         = 32'h694b747f;
      rows         = 0;
      cycles       = 0;
      cycleLimit   = 0;
      buildTable();
      cycleLimit = progInstrs * 40;
      for (int i = 0; i < rows; i++) begin
         cycleLimit = cycleLimit + waitTable[i];
      end
      wait (reset === 1'b1);
      for (int i = 0; i < rows; i++) begin
         wait (received > i);
         returnCredit(waitTable[i]);
      end
      repeat (20) @(posedge clk);  // Catch stray words
      $display("Rows passed %0d, failed checks %0d", passCount, failCount);
      if (failCount == 0 && passCount == rows) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // Run limit from program length and credit waits
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycleLimit != 0 && cycles >= cycleLimit) begin
         $display("Timeout after %0d cycles, the program never finished", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

endmodule

// ==== tb/consoleMonitor.sv ====
//******************************
// consoleMonitor
// Compares console words with the expected table and checks credit rules
//******************************

module consoleMonitor #(
   parameter int credits = 4  // Far end grant after reset
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            txValid,
   input  femtoPkg::word_t txData,
   input  logic            creditReturn,
   input  femtoPkg::word_t expWord,   // Row at index received
   input  int              expGroup,
   input  int              rows,
   output int              received,
   output int              passCount,
   output int              failCount
);
   import femtoPkg::*;

   int outstanding;  // Words sent with credit not yet back

   function automatic string groupName(input int g);
      case (g)
         1:       return "arith";
         2:       return "shift";
         3:       return "memory";
         4:       return "control";
         5:       return "credit";
         default: return "unknown";
      endcase
   endfunction

   initial begin
      received    = 0;
      passCount   = 0;
      failCount   = 0;
      outstanding = 0;
   end

   // Sampled mid cycle where DUT outputs are settled
   always @(negedge clk) begin
      if (!reset) begin
         if (txValid) begin
            $display("Console word sent while reset was asserted at %0t", $time);
            failCount = failCount + 1;
         end
      end else begin
         if (txValid) begin
            if (outstanding >= credits) begin
               $display("Word sent at %0t with no credit left", $time);
               failCount = failCount + 1;
            end
            if (received >= rows) begin
               $display("Extra console word %h at %0t after the last row", txData, $time);
               failCount = failCount + 1;
            end else if (txData !== expWord) begin
               $display("Fail at %0t: row %0d (%s) got %h expected %h",
                        $time, received, groupName(expGroup), txData, expWord);
               failCount = failCount + 1;
            end else begin
               $display("Row %0d (%s) ok: %h", received, groupName(expGroup), txData);
               passCount = passCount + 1;
            end
            received    = received + 1;
            outstanding = outstanding + 1;
         end
         if (creditReturn) begin
            outstanding = outstanding - 1;  // Far end hands one back
         end
      end
   end

endmodule

// ==== tb/clockGen.sv ====
//******************************
// clockGen
// Testbench clock and active low reset
//******************************

module clockGen #(
   parameter int period      = 100,
   parameter int resetCycles = 2
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk   = 1'b0;
      reset = 1'b0;  // Held low from time zero
      repeat (resetCycles) @(posedge clk);
      #10 reset = 1'b1;  // Released just after an edge
   end

   always #(period / 2) clk = ~clk;

endmodule

// ==== hw/femtoSoc.sv ====
//******************************
// femtoSoc
// Core, bus splitter, program RAM and console port
//******************************

module femtoSoc #(
   parameter femtoPkg::word_t resetAddr      = 32'h0000_0000,
   parameter int              ramWords       = 1024,   // 4 KB
   parameter logic [3:0]      consoleCredits = 4'd4,
   parameter int              queueDepth     = 4
) (
   input  logic            clk,
   input  logic            reset,
   output logic            txValid,
   output femtoPkg::word_t txData,
   input  logic            creditReturn
);
   import femtoPkg::*;

   memBus coreBus ();  // Core to splitter
   memBus ramBus ();   // Splitter to RAM

   // Console port wires
   logic  conSel;
   logic  conWrite;
   word_t conWdata;
   word_t conRdata;
   logic  conWbusy;

   femtoCore #(.resetAddr(resetAddr)) core (
      .clk   (clk),
      .reset (reset),
      .bus   (coreBus.core)
   );

   busSplit split (
      .clk      (clk),
      .reset    (reset),
      .core     (coreBus.target),
      .ram      (ramBus.core),
      .conSel   (conSel),
      .conWrite (conWrite),
      .conWdata (conWdata),
      .conRdata (conRdata),
      .conWbusy (conWbusy)
   );

   progRam #(.ramWords(ramWords)) ram (
      .clk (clk),
      .bus (ramBus.target)
   );

   consoleOut #(
      .consoleCredits (consoleCredits),
      .queueDepth     (queueDepth)
   ) console (
      .clk          (clk),
      .reset        (reset),
      .sel          (conSel),
      .write        (conWrite),
      .wdata        (conWdata),
      .rdata        (conRdata),
      .wbusy        (conWbusy),
      .txValid      (txValid),
      .txData       (txData),
      .creditReturn (creditReturn)
   );

endmodule

// ==== hw/consoleOut.sv ====
//******************************
// consoleOut
// Word queue drained to the outside under credit flow control
//******************************

module consoleOut #(
   parameter logic [3:0] consoleCredits = 4'd4,
   parameter int         queueDepth     = 4
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            sel,
   input  logic            write,
   input  femtoPkg::word_t wdata,
   output femtoPkg::word_t rdata,
   output logic            wbusy,
   output logic            txValid,
   output femtoPkg::word_t txData,
   input  logic            creditReturn
);
   import femtoPkg::*;

   localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
   localparam int cntBits = $clog2(queueDepth + 1);

   word_t              queue [queueDepth];
   logic [ptrBits-1:0] wrPtr;
   logic [ptrBits-1:0] rdPtr;
   logic [cntBits-1:0] count;     // Words in the queue
   logic [3:0]         credits;   // Free credits at the far end
   logic               pending;   // Write taken while full
   word_t              pendData;
   logic               full;
   logic               push;
   logic               pop;

   assign full = count == cntBits'(queueDepth);
   assign pop  = (count != '0) & (credits != 4'd0);  // Send this cycle
   assign push = (pending | write) & !full;

   assign wbusy   = pending | (write & full);  // Held until a slot frees
   assign txValid = pop;
   assign txData  = queue[rdPtr];

   //******************************
   // Pointers, count and credits
   //******************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         wrPtr   <= '0;
         rdPtr   <= '0;
         count   <= '0;
         credits <= consoleCredits;  // Initial grant
         pending <= 1'b0;
      end else begin
         if (push) begin
            wrPtr <= (wrPtr == ptrBits'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= (rdPtr == ptrBits'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
         end
         count   <= count + cntBits'(push) - cntBits'(pop);
         credits <= credits + 4'(creditReturn) - 4'(pop);  // Send and return cancel
         if (write & full) begin
            pending <= 1'b1;
         end else if (push) begin
            pending <= 1'b0;
         end
      end
   end

   // Queue payload and read data
   always_ff @(posedge clk) begin
      if (push) begin
         queue[wrPtr] <= pending ? pendData : wdata;
      end
      if (write & full) begin
         pendData <= wdata;
      end
      if (sel) begin
         rdata <= word_t'(credits);  // Credit count on reads
      end
   end

endmodule

// ==== hw/progRam.sv ====
//******************************
// progRam
// Program and data RAM, byte writable, loaded from hex,
// read data one cycle after the strobe
//******************************

module progRam #(
   parameter int ramWords = 1024
) (
   input logic   clk,
   memBus.target bus
);
   import femtoPkg::*;

   localparam int idxBits = $clog2(ramWords);

   word_t              mem [ramWords];
   logic [idxBits-1:0] idx;  // Word index

   assign idx = bus.addr[idxBits+1:2];  // Drop byte offset

   // Program image
   initial begin
      $readmemh("tb/prog.hex", mem);
   end

   always_ff @(posedge clk) begin
      if (bus.rstrb) begin
         bus.rdata <= mem[idx];
      end
      // Each lane under its own mask bit
      for (int lane = 0; lane < laneCount; lane++) begin
         if (bus.wmask[lane]) begin
            mem[idx][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
         end
      end
   end

   assign bus.rbusy = 1'b0;  // Never stalls
   assign bus.wbusy = 1'b0;

endmodule

// ==== hw/busSplit.sv ====
//******************************
// busSplit
// Routes core accesses to RAM or console by address, merges replies
//******************************

module busSplit (
   input  logic            clk,
   input  logic            reset,
   memBus.target           core,
   memBus.core             ram,
   output logic            conSel,
   output logic            conWrite,
   output femtoPkg::word_t conWdata,
   input  femtoPkg::word_t conRdata,
   input  logic            conWbusy
);
   import femtoPkg::*;

   logic conHit;   // Current address is the console
   logic readCon;  // Last read strobe went to the console

   assign conHit = core.addr[31:consoleSelBit] == consoleBase[31:consoleSelBit];

   // RAM side, strobes blocked on console hits
   assign ram.addr  = core.addr;
   assign ram.wdata = core.wdata;
   assign ram.wmask = conHit ? '0 : core.wmask;
   assign ram.rstrb = core.rstrb & !conHit;

   // Console side
   assign conSel   = conHit;
   assign conWrite = conHit & (|core.wmask);
   assign conWdata = core.wdata;

   always_ff @(posedge clk) begin
      if (!reset) begin
         readCon <= 1'b0;
      end else if (core.rstrb) begin
         readCon <= conHit;
      end
   end

   assign core.rdata = readCon ? conRdata : ram.rdata;  // Follows one cycle latency
   assign core.rbusy = ram.rbusy;                       // Console reads never stall
   assign core.wbusy = ram.wbusy | conWbusy;

endmodule

// ==== hw/femtoCore.sv ====
//******************************
// femtoCore
// Multi-cycle RV32I core, one-hot FSM, serial shifter,
// aligned byte and halfword loads and stores
//******************************

module femtoCore #(
   parameter femtoPkg::word_t resetAddr = 32'h0000_0000
) (
   input  logic clk,
   input  logic reset,
   memBus.core  bus
);
   import femtoPkg::*;

   word_t      instr;          // Latched instruction
   word_t      pc;
   coreState_t state;
   logic       writeBack;      // Register file write enable
   word_t      writeBackData;

   //******************************
   // Decode
   //******************************
   wire [4:0] rdId  = instr[11:7];
   wire [4:0] rs1Id = instr[19:15];
   wire [4:0] rs2Id = instr[24:20];
   wire [2:0] func  = instr[14:12];

   wire funcIsShift = (func == 3'b001) | (func == 3'b101);
   wire funcQual    = (funcIsShift | instr[5]) & instr[30];  // SUB or SRA

   // Immediate formats
   wire [31:0] uImm = {instr[31:12], 12'b0};
   wire [31:0] iImm = {{21{instr[31]}}, instr[30:20]};
   wire [31:0] sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   wire [31:0] bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   wire [31:0] jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // Opcode classes
   wire isLoad   = instr[6:2] == 5'b00000;
   wire isAluImm = instr[6:2] == 5'b00100;
   wire isAuipc  = instr[6:2] == 5'b00101;
   wire isStore  = instr[6:2] == 5'b01000;
   wire isAluReg = instr[6:2] == 5'b01100;
   wire isLui    = instr[6:2] == 5'b01101;
   wire isBranch = instr[6:2] == 5'b11000;
   wire isJalr   = instr[6:2] == 5'b11001;
   wire isJal    = instr[6:2] == 5'b11011;

   word_t imm;
   always_comb begin
      case (instr[6:2])
         5'b01101, 5'b00101: imm = uImm;  // LUI, AUIPC
         5'b11011:           imm = jImm;
         5'b11000:           imm = bImm;
         5'b01000:           imm = sImm;
         default:            imm = iImm;  // Loads, ALU imm, JALR
      endcase
   end

   //******************************
   // Register file
   //******************************
   word_t regFile [32];
   word_t regOut1;
   word_t regOut2;

   // Operands ready one cycle after the ids
   always_ff @(posedge clk) begin
      regOut1 <= (rs1Id == 5'd0) ? '0 : regFile[rs1Id];  // x0 reads as zero
      regOut2 <= (rs2Id == 5'd0) ? '0 : regFile[rs2Id];
      if (writeBack && rdId != 5'd0) begin
         regFile[rdId] <= writeBackData;
      end
   end

   //******************************
   // ALU
   //******************************
   word_t      aluReg;   // Result, also the shift register
   logic [4:0] shamt;    // Remaining shift steps
   wire        aluBusy = shamt != 5'd0;
   wire        aluWr   = state.execute & (isAluImm | isAluReg);

   wire [31:0] aluIn1  = regOut1;
   wire [31:0] aluIn2  = (isAluReg | isBranch) ? regOut2 : imm;
   wire [31:0] aluPlus = aluIn1 + aluIn2;  // Also load and store address

   // One subtraction feeds SUB and every compare
   wire [32:0] minus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + 33'd1;
   wire        lt    = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : minus[32];
   wire        ltu   = minus[32];
   wire        eq    = minus[31:0] == 32'd0;

   always_ff @(posedge clk) begin
      if (!reset) begin
         shamt <= 5'd0;
      end else if (aluWr) begin
         shamt <= funcIsShift ? aluIn2[4:0] : 5'd0;
      end else if (aluBusy) begin
         shamt <= shamt - 5'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (aluWr) begin
         case (func)
            3'b000:         aluReg <= funcQual ? minus[31:0] : aluPlus;  // ADD, SUB
            3'b010:         aluReg <= {31'b0, lt};
            3'b011:         aluReg <= {31'b0, ltu};
            3'b100:         aluReg <= aluIn1 ^ aluIn2;
            3'b110:         aluReg <= aluIn1 | aluIn2;
            3'b111:         aluReg <= aluIn1 & aluIn2;
            default:        aluReg <= aluIn1;  // Shift source
         endcase
      end else if (aluBusy) begin
         // One bit per cycle
         if (func == 3'b001) begin
            aluReg <= aluReg << 1;
         end else begin
            aluReg <= {funcQual & aluReg[31], aluReg[31:1]};  // SRA keeps sign, SRL zero
         end
      end
   end

   //******************************
   // Branches and jumps
   //******************************
   logic predicate;
   always_comb begin
      case (func)
         3'b000:  predicate = eq;
         3'b001:  predicate = !eq;
         3'b100:  predicate = lt;
         3'b101:  predicate = !lt;
         3'b110:  predicate = ltu;
         3'b111:  predicate = !ltu;
         default: predicate = 1'b0;
      endcase
   end

   wire        takeBranch   = isJal | (isBranch & predicate);
   wire [31:0] pcPlus4      = pc + 32'd4;
   wire [31:0] branchTarget = pc + imm;  // Branch, JAL and AUIPC
   wire [31:0] jalrTarget   = {aluPlus[31:1], 1'b0};

   //******************************
   // Load and store alignment
   //******************************
   wire byteAccess = func[1:0] == 2'b00;
   wire halfAccess = func[1:0] == 2'b01;

   wire [15:0] loadHalf = bus.addr[1] ? bus.rdata[31:16] : bus.rdata[15:0];
   wire [7:0]  loadByte = bus.addr[0] ? loadHalf[15:8] : loadHalf[7:0];
   wire        loadSign = !func[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   wire [31:0] loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                          halfAccess ? {{16{loadSign}}, loadHalf} : bus.rdata;

   // Replicate low bytes so every lane sees its data
   assign bus.wdata[7:0]   = regOut2[7:0];
   assign bus.wdata[15:8]  = aluPlus[0] ? regOut2[7:0] : regOut2[15:8];
   assign bus.wdata[23:16] = aluPlus[1] ? regOut2[7:0] : regOut2[23:16];
   assign bus.wdata[31:24] = aluPlus[0] ? regOut2[7:0] :
                             aluPlus[1] ? regOut2[15:8] : regOut2[31:24];

   wmask_t storeMask;
   always_comb begin
      if (byteAccess) begin
         storeMask = wmask_t'(4'b0001 << aluPlus[1:0]);
      end else if (halfAccess) begin
         storeMask = aluPlus[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

   assign writeBackData = (isLui               ? imm          : 32'b0) |
                          (isAluImm | isAluReg ? aluReg       : 32'b0) |
                          (isAuipc             ? branchTarget : 32'b0) |
                          (isJalr | isJal      ? pcPlus4      : 32'b0) |
                          (isLoad              ? loadData     : 32'b0);

   //******************************
   // State machine
   //******************************
   assign writeBack = (state.execute & ~(isBranch | isStore)) | state.waitAluOrData;
   assign bus.rstrb = state.fetchInstr | state.load;
   assign bus.wmask = state.store ? storeMask : '0;

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= '{waitIoStore: 1'b1, default: 1'b0};  // First fetch after wbusy check
         pc    <= resetAddr;
      end else begin
         case (1'b1)
            state.execute: begin
               pc       <= isJalr ? jalrTarget : (takeBranch ? branchTarget : pcPlus4);
               bus.addr <= isJalr            ? jalrTarget   :
                           (isLoad | isStore) ? aluPlus      :
                           takeBranch        ? branchTarget : pcPlus4;
               state    <= '{waitIoStore: 1'b0, store: isStore,
                             waitAluOrData: isAluImm | isAluReg, load: isLoad,
                             execute: 1'b0, fetchRegs: 1'b0, waitInstr: 1'b0,
                             fetchInstr: !(isStore | isAluImm | isAluReg | isLoad)};
            end
            state.waitInstr: begin
               if (!bus.rbusy) begin
                  instr <= bus.rdata;
                  state <= '{fetchRegs: 1'b1, default: 1'b0};
               end
            end
            state.waitAluOrData, state.waitIoStore: begin
               if (!aluBusy & !bus.rbusy & !bus.wbusy) begin
                  bus.addr <= pc;
                  state    <= '{fetchInstr: 1'b1, default: 1'b0};
               end
            end
            default: begin
               // Fixed one step hops
               state <= '{waitIoStore: state.store, store: 1'b0,
                          waitAluOrData: state.load, load: 1'b0,
                          execute: state.fetchRegs, fetchRegs: 1'b0,
                          waitInstr: state.fetchInstr, fetchInstr: 1'b0};
            end
         endcase
      end
   end

endmodule

// ==== hw/memBus.sv ====
//******************************
// memBus
// Core memory bus with read strobe, byte write mask and busy lines
//******************************

interface memBus;
   import femtoPkg::*;

   word_t  addr;    // Byte address
   word_t  wdata;   // Lane aligned write data
   wmask_t wmask;   // Nonzero for one cycle on a write
   word_t  rdata;   // Valid the cycle after rstrb, once rbusy low
   logic   rstrb;   // One cycle read request
   logic   rbusy;
   logic   wbusy;   // Target still holds a pending write

   // Initiator side
   modport core (
      output addr, wdata, wmask, rstrb,
      input  rdata, rbusy, wbusy
   );

   // Responder side
   modport target (
      input  addr, wdata, wmask, rstrb,
      output rdata, rbusy, wbusy
   );

endinterface

// ==== hw/femtoPkg.sv ====
//******************************
// femtoPkg
// Shared types and constants for the femto SoC: bus word, byte mask,
// one-hot core state and the console address decode
//******************************

package femtoPkg;

   //******************************
   // Bus widths
   //******************************
   localparam int wordBits  = 32;
   localparam int laneCount = wordBits / 8;  // Byte lanes per word

   typedef logic [wordBits-1:0]  word_t;     // Address or data word
   typedef logic [laneCount-1:0] wmask_t;    // One bit per byte lane

   // One-hot core states, MSB first
   typedef struct packed {
      logic waitIoStore;    // Waits for wbusy low, also the reset state
      logic store;          // Write mask pulse
      logic waitAluOrData;  // Shift in progress or load data back
      logic load;           // Read strobe for a load
      logic execute;
      logic fetchRegs;      // Register file read
      logic waitInstr;
      logic fetchInstr;     // Read strobe for the next instruction
   } coreState_t;

   //******************************
   // Memory map
   //******************************
   localparam word_t      consoleBase   = 32'h0040_0000;  // Bit 22 picks the console
   localparam logic [4:0] consoleSelBit = 5'd22;

endpackage
